// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dragon_engine_tb
RTL_TOP   = dragon_engine
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+logic
logic/grid_geometry_pkg.sv
logic/dragon_behaviour_pkg.sv
logic/dragon_config_regs.sv
logic/dragon_target_select.sv
logic/dragon_head_stepper.sv
logic/dragon_behaviour_fsm.sv
logic/dragon_engine.sv
verif/dragon_engine_tb.sv

// ==== logic/dragon_behaviour_fsm.sv ====
// Registered head, facing, length and behaviour state of the dragon, with event pulses
`default_nettype none
`timescale 1ns/1ps

`include "dragon_settings.svh"

module dragon_behaviour_fsm (
    input  wire logic                            frame_clk,
    input  wire logic                            rst,
    input  wire logic                            step,          // One move per strobe
    input  wire logic                            player_strike, // Sampled with step
    input  wire grid_geometry_pkg::tile_t        player_tile,
    input  wire grid_geometry_pkg::tile_t        sheep_tile,
    input  wire grid_geometry_pkg::tile_t        target_tile,
    input  wire grid_geometry_pkg::tile_t        next_tile,
    input  wire grid_geometry_pkg::dir_t         next_dir,
    input  wire dragon_behaviour_pkg::length_t   growth_limit,
    output grid_geometry_pkg::tile_t             head_tile,
    output grid_geometry_pkg::dir_t              head_dir,
    output dragon_behaviour_pkg::length_t        body_length,
    output dragon_behaviour_pkg::behaviour_t     behaviour_state,
    output logic                                 sheep_eaten,
    output logic                                 player_caught,
    output logic                                 dragon_hurt
);

    import grid_geometry_pkg::*;
    import dragon_behaviour_pkg::*;

    logic    hits_player;   // New head lands on the player
    logic    hits_sheep;    // New head lands on the sheep
    logic    at_target;
    length_t length_dec;
    length_t length_inc;    // Grown length, clamped to the limit

    assign hits_player = (next_tile == player_tile);
    assign hits_sheep  = (next_tile == sheep_tile);
    assign at_target   = (next_tile == target_tile);

    assign length_dec = body_length - 1'b1;
    assign length_inc = (body_length >= growth_limit) ? growth_limit : body_length + 1'b1;

    always_ff @(posedge frame_clk) begin
        if (rst) begin
            head_tile       <= `DRAGON_START_TILE;
            head_dir        <= dir_up;
            body_length     <= length_t'(`DRAGON_START_LENGTH);
            behaviour_state <= beh_scatter;
            sheep_eaten     <= 1'b0;
            player_caught   <= 1'b0;
            dragon_hurt     <= 1'b0;
        end else begin
            // Pulses last one cycle
            sheep_eaten   <= 1'b0;
            player_caught <= 1'b0;
            dragon_hurt   <= 1'b0;

            if (step && behaviour_state != beh_dead) begin
                head_tile <= next_tile;
                head_dir  <= next_dir;

                case (behaviour_state)
                    beh_contest: begin
                        // Player outranks the sheep when both share the tile
                        if (hits_player && player_strike) begin
                            dragon_hurt     <= 1'b1;
                            body_length     <= length_dec;
                            behaviour_state <= (length_dec == '0) ? beh_dead : beh_retreat;
                        end else if (hits_player) begin
                            player_caught   <= 1'b1;
                            behaviour_state <= beh_scatter;
                        end else if (hits_sheep) begin
                            sheep_eaten     <= 1'b1;
                            body_length     <= length_inc;
                            behaviour_state <= beh_scatter;
                        end
                    end
                    beh_retreat, beh_scatter: begin
                        if (at_target) begin
                            behaviour_state <= beh_contest;   // Back into the fight
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Growth never carries the length past the limit in force at that step
    a_length_limit: assert property (
        @(posedge frame_clk) disable iff (rst)
        (body_length > $past(body_length)) |-> (body_length <= $past(growth_limit))
    ) else $error("body length grew past growth_limit");

    // Head moves at most one tile per axis on a step
    a_single_tile: assert property (
        @(posedge frame_clk) disable iff (rst)
        step |=> (coord_dist(tile_row(head_tile), tile_row($past(head_tile))) <= 1)
              && (coord_dist(tile_col(head_tile), tile_col($past(head_tile))) <= 1)
    ) else $error("head jumped more than one tile");

endmodule

`default_nettype wire

// ==== logic/dragon_behaviour_pkg.sv ====
// Behaviour state, body length and config register address types for the dragon engine
`default_nettype none

package dragon_behaviour_pkg;

    // Behaviour state
    typedef enum logic [1:0] {
        beh_contest = 2'b00,   // Chase the nearer of player and sheep
        beh_retreat = 2'b01,   // Run to the corner away from the player
        beh_scatter = 2'b10,   // Head for the configured tile
        beh_dead    = 2'b11    // Game over, steps ignored until reset
    } behaviour_t;

    // Body length, zero only once the dragon is dead
    typedef logic [3:0] length_t;

    // Config register addresses
    typedef enum logic {
        cfg_scatter_tile = 1'b0,   // Scatter target tile
        cfg_growth_limit = 1'b1    // Largest body length
    } cfg_addr_t;

endpackage

`default_nettype wire

// ==== logic/dragon_config_regs.sv ====
// Register block for the scatter tile and growth limit, written by a single-cycle strobe
`default_nettype none
`timescale 1ns/1ps

`include "dragon_settings.svh"

module dragon_config_regs (
    input  wire logic                          frame_clk,
    input  wire logic                          rst,
    input  wire logic                          cfg_write,    // Write strobe
    input  wire dragon_behaviour_pkg::cfg_addr_t cfg_addr,
    input  wire grid_geometry_pkg::tile_t      cfg_data,
    output grid_geometry_pkg::tile_t           scatter_tile,
    output dragon_behaviour_pkg::length_t      growth_limit
);

    import dragon_behaviour_pkg::*;

    length_t limit_raw;     // Low nibble of the write data
    length_t limit_wdata;   // Same nibble with zero promoted to one

    assign limit_raw = cfg_data[$bits(length_t)-1:0];

    // A limit of zero would leave no room for a body
    assign limit_wdata = (limit_raw == '0) ? length_t'(1) : limit_raw;

    always_ff @(posedge frame_clk) begin
        if (rst) begin
            scatter_tile <= `DRAGON_SCATTER_RESET;
            growth_limit <= length_t'(`DRAGON_LIMIT_RESET);
        end else if (cfg_write) begin
            case (cfg_addr)
                cfg_scatter_tile: scatter_tile <= cfg_data;       // Whole byte is the tile
                cfg_growth_limit: growth_limit <= limit_wdata;
                default: ;
            endcase
        end
    end

    // Engine relies on a nonzero limit when clamping growth
    a_limit_nonzero: assert property (
        @(posedge frame_clk) disable iff (rst)
        growth_limit != '0
    ) else $error("growth_limit reached zero");

endmodule

`default_nettype wire

// ==== logic/dragon_engine.sv ====
// Dragon movement engine top, joins config registers, target select, stepper and FSM
`default_nettype none
`timescale 1ns/1ps

module dragon_engine (
    input  wire logic                              frame_clk,
    input  wire logic                              rst,
    input  wire logic                              step,
    input  wire logic                              player_strike,
    input  wire grid_geometry_pkg::tile_t          player_tile,
    input  wire grid_geometry_pkg::tile_t          sheep_tile,
    input  wire logic                              cfg_write,
    input  wire dragon_behaviour_pkg::cfg_addr_t   cfg_addr,
    input  wire grid_geometry_pkg::tile_t          cfg_data,
    output wire grid_geometry_pkg::tile_t          head_tile,
    output wire grid_geometry_pkg::dir_t           head_dir,
    output wire dragon_behaviour_pkg::length_t     body_length,
    output wire dragon_behaviour_pkg::behaviour_t  behaviour_state,
    output wire logic                              sheep_eaten,
    output wire logic                              player_caught,
    output wire logic                              dragon_hurt
);

    import grid_geometry_pkg::*;
    import dragon_behaviour_pkg::*;

    tile_t   scatter_tile;   // From the register block
    length_t growth_limit;
    tile_t   target_tile;    // Chosen goal this cycle
    tile_t   next_tile;      // Head after one step
    dir_t    next_dir;

    dragon_config_regs u_config_regs (
        .frame_clk    (frame_clk),
        .rst          (rst),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .scatter_tile (scatter_tile),
        .growth_limit (growth_limit)
    );

    // Goal follows the registered state and head
    dragon_target_select u_target_select (
        .state        (behaviour_state),
        .head_tile    (head_tile),
        .player_tile  (player_tile),
        .sheep_tile   (sheep_tile),
        .scatter_tile (scatter_tile),
        .target_tile  (target_tile)
    );

    dragon_head_stepper u_head_stepper (
        .head_tile   (head_tile),
        .head_dir    (head_dir),
        .target_tile (target_tile),
        .next_tile   (next_tile),
        .next_dir    (next_dir)
    );

    dragon_behaviour_fsm u_behaviour_fsm (
        .frame_clk       (frame_clk),
        .rst             (rst),
        .step            (step),
        .player_strike   (player_strike),
        .player_tile     (player_tile),
        .sheep_tile      (sheep_tile),
        .target_tile     (target_tile),
        .next_tile       (next_tile),
        .next_dir        (next_dir),
        .growth_limit    (growth_limit),
        .head_tile       (head_tile),
        .head_dir        (head_dir),
        .body_length     (body_length),
        .behaviour_state (behaviour_state),
        .sheep_eaten     (sheep_eaten),
        .player_caught   (player_caught),
        .dragon_hurt     (dragon_hurt)
    );

endmodule

`default_nettype wire

// ==== logic/dragon_head_stepper.sv ====
// Combinational one-tile step of the dragon head toward its target, with the new facing
`default_nettype none
`timescale 1ns/1ps

module dragon_head_stepper (
    input  wire grid_geometry_pkg::tile_t head_tile,
    input  wire grid_geometry_pkg::dir_t  head_dir,
    input  wire grid_geometry_pkg::tile_t target_tile,
    output grid_geometry_pkg::tile_t      next_tile,
    output grid_geometry_pkg::dir_t       next_dir
);

    import grid_geometry_pkg::*;

    coord_t head_row;
    coord_t head_col;
    coord_t next_row;
    coord_t next_col;

    // One unit toward the goal, none when already there
    function automatic coord_t step_toward(coord_t from, coord_t goal);
        if (from < goal) begin
            return from + 1'b1;
        end else if (from > goal) begin
            return from - 1'b1;
        end
        return from;
    endfunction

    assign head_row = tile_row(head_tile);
    assign head_col = tile_col(head_tile);

    // Both axes step together, diagonal moves allowed
    assign next_row = step_toward(head_row, tile_row(target_tile));
    assign next_col = step_toward(head_col, tile_col(target_tile));

    assign next_tile = make_tile(next_row, next_col);

    // Column movement wins the facing
    always_comb begin
        if (next_col > head_col) begin
            next_dir = dir_right;
        end else if (next_col < head_col) begin
            next_dir = dir_left;
        end else if (next_row > head_row) begin
            next_dir = dir_down;    // Rows count downward
        end else if (next_row < head_row) begin
            next_dir = dir_up;
        end else begin
            next_dir = head_dir;    // No move, keep facing
        end
    end

endmodule

`default_nettype wire

// ==== logic/dragon_settings.svh ====
// Grid size, start values and register reset values; include wherever these are needed
`ifndef DRAGON_SETTINGS_SVH
`define DRAGON_SETTINGS_SVH

// Grid geometry
// Bits per row or column, 16 by 16 grid
`define GRID_COORD_BITS 4

// Dragon start values
`define DRAGON_START_TILE 8'h88     // Row 8, column 8, middle of the grid
`define DRAGON_START_LENGTH 3       // Body length after reset

// Config register reset values
// Scatter toward the top left corner
`define DRAGON_SCATTER_RESET 8'h00

// Largest length the dragon may grow to
`define DRAGON_LIMIT_RESET 15

`endif

// ==== logic/dragon_target_select.sv ====
// Combinational target choice for the dragon head from behaviour state and entity tiles
`default_nettype none
`timescale 1ns/1ps

module dragon_target_select (
    input  wire dragon_behaviour_pkg::behaviour_t state,
    input  wire grid_geometry_pkg::tile_t         head_tile,
    input  wire grid_geometry_pkg::tile_t         player_tile,
    input  wire grid_geometry_pkg::tile_t         sheep_tile,
    input  wire grid_geometry_pkg::tile_t         scatter_tile,
    output grid_geometry_pkg::tile_t              target_tile
);

    import grid_geometry_pkg::*;
    import dragon_behaviour_pkg::*;

    coord_t head_row;
    coord_t head_col;
    coord_t player_row;
    coord_t player_col;
    coord_t sheep_row;
    coord_t sheep_col;

    dist_t  dist_player;     // Head to player, Manhattan
    dist_t  dist_sheep;      // Head to sheep, Manhattan
    logic   player_nearer;   // Strictly nearer, ties go to the sheep

    coord_t retreat_row;
    coord_t retreat_col;

    // Split tiles into coordinates
    assign head_row   = tile_row(head_tile);
    assign head_col   = tile_col(head_tile);
    assign player_row = tile_row(player_tile);
    assign player_col = tile_col(player_tile);
    assign sheep_row  = tile_row(sheep_tile);
    assign sheep_col  = tile_col(sheep_tile);

    // Sums widened by one bit so 15 + 15 does not wrap
    assign dist_player = dist_t'(coord_dist(head_row, player_row))
                       + dist_t'(coord_dist(head_col, player_col));
    assign dist_sheep  = dist_t'(coord_dist(head_row, sheep_row))
                       + dist_t'(coord_dist(head_col, sheep_col));

    assign player_nearer = (dist_player < dist_sheep);

    // Farthest corner from the player, decided per axis
    assign retreat_row = (player_row < coord_mid) ? coord_max : '0;   // Player on top half
    assign retreat_col = (player_col < coord_mid) ? coord_max : '0;   // Player on left half

    always_comb begin
        case (state)
            beh_contest: target_tile = player_nearer ? player_tile : sheep_tile;
            beh_retreat: target_tile = make_tile(retreat_row, retreat_col);
            beh_scatter: target_tile = scatter_tile;
            // Dead: aim at the head itself so nothing moves
            default:     target_tile = head_tile;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/grid_geometry_pkg.sv ====
// Tile, coordinate and direction types plus small helpers, imported by the movement logic
`default_nettype none

`include "dragon_settings.svh"

package grid_geometry_pkg;

    typedef logic [`GRID_COORD_BITS-1:0]   coord_t;   // One row or one column
    typedef logic [2*`GRID_COORD_BITS-1:0] tile_t;    // Row in the upper half, column below
    typedef logic [`GRID_COORD_BITS:0]     dist_t;    // Manhattan distance, one bit wider

    // Facing direction, encoding as in the game
    typedef enum logic [1:0] {
        dir_up    = 2'b00,
        dir_right = 2'b01,
        dir_down  = 2'b10,   // Row count grows downward
        dir_left  = 2'b11
    } dir_t;

    localparam coord_t coord_max = '1;                                 // Last row or column
    localparam coord_t coord_mid = coord_t'(1 << (`GRID_COORD_BITS - 1)); // Grid halfway mark

    function automatic coord_t tile_row(tile_t tile);
        return tile[2*`GRID_COORD_BITS-1:`GRID_COORD_BITS];
    endfunction

    function automatic coord_t tile_col(tile_t tile);
        return tile[`GRID_COORD_BITS-1:0];
    endfunction

    function automatic tile_t make_tile(coord_t row, coord_t col);
        return {row, col};
    endfunction

    // Absolute difference of two coordinates
    function automatic coord_t coord_dist(coord_t a, coord_t b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

endpackage

`default_nettype wire

// ==== verif/dragon_engine_tb.sv ====
// Self-checking testbench for the dragon engine; compile with build.f and run through the Makefile
`default_nettype none
`timescale 1ns/1ps

`include "dragon_settings.svh"

module dragon_engine_tb;

    import grid_geometry_pkg::*;
    import dragon_behaviour_pkg::*;

    logic       frame_clk;
    logic       rst = 1'b1;
    logic       step = 1'b0;
    logic       player_strike = 1'b0;
    tile_t      player_tile = '0;
    tile_t      sheep_tile = '0;
    logic       cfg_write = 1'b0;
    cfg_addr_t  cfg_addr = cfg_scatter_tile;
    tile_t      cfg_data = '0;
    tile_t      head_tile;
    dir_t       head_dir;
    length_t    body_length;
    behaviour_t behaviour_state;
    logic       sheep_eaten;
    logic       player_caught;
    logic       dragon_hurt;

    tile_t      exp_head;       // Reference model of the registered outputs
    dir_t       exp_dir;
    length_t    exp_len;
    behaviour_t exp_state;
    logic [2:0] exp_pulses;     // Sheep eaten, player caught, dragon hurt
    tile_t      exp_scatter;    // Model copies of the config registers
    length_t    exp_limit;

    logic [31:0] lfsr = 32'he0ce;
    string       test_name = "none";
    int          errors = 0;
    int          errors_before = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    dragon_engine DUT (.*);

    initial begin
        frame_clk = 1'b0;
        forever #10 frame_clk = ~frame_clk;   // 20 ns period
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_advance(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int manhattan(tile_t a, tile_t b);
        int dr;
        int dc;
        dr = int'(a[7:4]) - int'(b[7:4]);
        dc = int'(a[3:0]) - int'(b[3:0]);
        return (dr < 0 ? -dr : dr) + (dc < 0 ? -dc : dc);
    endfunction

    // One tile toward the goal on each axis so diagonals are allowed
    function automatic tile_t move_toward(tile_t from, tile_t goal);
        int r;
        int c;
        r = int'(from[7:4]) + (goal[7:4] > from[7:4] ? 1 : 0) - (goal[7:4] < from[7:4] ? 1 : 0);
        c = int'(from[3:0]) + (goal[3:0] > from[3:0] ? 1 : 0) - (goal[3:0] < from[3:0] ? 1 : 0);
        return tile_t'(r * 16 + c);
    endfunction

    function automatic tile_t pick_target(behaviour_t st, tile_t head, tile_t p, tile_t s,
                                          tile_t sc);
        case (st)
            beh_contest: return (manhattan(head, p) < manhattan(head, s)) ? p : s;  // Tie to sheep
            beh_retreat: return tile_t'((p[7:4] < 4'd8 ? 15 : 0) * 16 + (p[3:0] < 4'd8 ? 15 : 0));
            beh_scatter: return sc;
            default:     return head;     // Dead stays put
        endcase
    endfunction

    // Column move sets the facing first and a row move second, otherwise keep
    function automatic dir_t facing_after(tile_t from, tile_t to, dir_t keep);
        int dr;
        int dc;
        dr = int'(to[7:4]) - int'(from[7:4]);
        dc = int'(to[3:0]) - int'(from[3:0]);
        if (dc != 0) return (dc > 0) ? dir_right : dir_left;
        if (dr != 0) return (dr > 0) ? dir_down : dir_up;
        return keep;
    endfunction

    // Diagonal neighbour that stays on the grid
    function automatic tile_t adjacent_tile(tile_t t);
        int r;
        int c;
        r = int'(t[7:4]);
        c = int'(t[3:0]);
        r = (r < 15) ? r + 1 : r - 1;
        c = (c < 15) ? c + 1 : c - 1;
        return tile_t'(r * 16 + c);
    endfunction

    // Same row two columns over on the side with room
    function automatic tile_t two_cols_away(tile_t t);
        return (t[3:0] < 4'd8) ? t + 8'd2 : t - 8'd2;
    endfunction

    // Reference model updated on the same edge as the DUT
    always @(posedge frame_clk) begin
        tile_t tgt;
        tile_t nxt;
        int    grown;
        if (rst) begin
            exp_head    <= `DRAGON_START_TILE;
            exp_dir     <= dir_up;
            exp_len     <= length_t'(`DRAGON_START_LENGTH);
            exp_state   <= beh_scatter;
            exp_pulses  <= 3'b000;
            exp_scatter <= `DRAGON_SCATTER_RESET;
            exp_limit   <= length_t'(`DRAGON_LIMIT_RESET);
        end else begin
            exp_pulses <= 3'b000;
            if (cfg_write && cfg_addr == cfg_scatter_tile) begin
                exp_scatter <= cfg_data;
            end
            if (cfg_write && cfg_addr == cfg_growth_limit) begin
                exp_limit <= (cfg_data[3:0] != 4'd0) ? cfg_data[3:0] : 4'd1;   // Zero kept as one
            end
            if (step && exp_state != beh_dead) begin
                tgt = pick_target(exp_state, exp_head, player_tile, sheep_tile, exp_scatter);
                nxt = move_toward(exp_head, tgt);
                exp_head <= nxt;
                exp_dir  <= facing_after(exp_head, nxt, exp_dir);
                if (exp_state == beh_contest && nxt == player_tile && player_strike) begin
                    exp_pulses <= 3'b001;
                    exp_len    <= exp_len - 4'd1;
                    exp_state  <= (exp_len == 4'd1) ? beh_dead : beh_retreat;
                end else if (exp_state == beh_contest && nxt == player_tile) begin
                    exp_pulses <= 3'b010;
                    exp_state  <= beh_scatter;
                end else if (exp_state == beh_contest && nxt == sheep_tile) begin
                    grown = int'(exp_len) + 1;
                    if (grown > int'(exp_limit)) grown = int'(exp_limit);   // Capped growth
                    exp_pulses <= 3'b100;
                    exp_len    <= length_t'(grown);
                    exp_state  <= beh_scatter;
                end else if (exp_state != beh_contest && nxt == tgt) begin
                    exp_state <= beh_contest;   // Arrived and back to the fight
                end
            end
        end
    end

    // Registers match the model one cycle after each step
    a_step_outputs: assert property (@(posedge frame_clk) disable iff (rst)
        step |=> {head_tile, head_dir, body_length, behaviour_state}
                 == {exp_head, exp_dir, exp_len, exp_state})
    else begin
        errors = errors + 1;
        $display("Mismatch %s head/dir/len/state expected %h/%0d/%0d/%0d actual %h/%0d/%0d/%0d",
                 test_name, $sampled(exp_head), $sampled(exp_dir), $sampled(exp_len),
                 $sampled(exp_state), $sampled(head_tile), $sampled(head_dir),
                 $sampled(body_length), $sampled(behaviour_state));
    end

    // Pulses high only in the cycle after the matching step
    a_pulses: assert property (@(posedge frame_clk) disable iff (rst)
        {sheep_eaten, player_caught, dragon_hurt} == exp_pulses)
    else begin
        errors = errors + 1;
        $display("Mismatch %s pulses expected %b actual %b", test_name, $sampled(exp_pulses),
                 $sampled({sheep_eaten, player_caught, dragon_hurt}));
    end

    a_reset_values: assert property (@(posedge frame_clk)
        $fell(rst) |-> head_tile == `DRAGON_START_TILE && head_dir == dir_up
            && body_length == length_t'(`DRAGON_START_LENGTH) && behaviour_state == beh_scatter
            && !(sheep_eaten || player_caught || dragon_hurt))
    else begin
        errors = errors + 1;
        $display("Mismatch %s reset outputs expected %h/%0d/%0d/%0d actual %h/%0d/%0d/%0d",
                 test_name, `DRAGON_START_TILE, dir_up, `DRAGON_START_LENGTH, beh_scatter,
                 $sampled(head_tile), $sampled(head_dir), $sampled(body_length),
                 $sampled(behaviour_state));
    end

    task automatic draw_tile(output tile_t t);
        t = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_advance(lfsr);
            t = {t[6:0], lfsr[0]};        // One LFSR step per bit
        end
    endtask

    task automatic apply_reset();
        @(negedge frame_clk);
        rst = 1'b1;
        repeat (16) @(negedge frame_clk);
        rst = 1'b0;
    endtask

    task automatic write_cfg(cfg_addr_t addr, tile_t data);
        @(negedge frame_clk);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge frame_clk);
        cfg_write = 1'b0;
    endtask

    task automatic take_step(tile_t p, tile_t s, logic strike);
        @(negedge frame_clk);
        step          = 1'b1;
        player_tile   = p;
        sheep_tile    = s;
        player_strike = strike;
        @(negedge frame_clk);
        step = 1'b0;
    endtask

    // Steps until the model leaves a state within max_steps
    task automatic step_until_left(behaviour_t st, tile_t p, tile_t s, logic strike,
                                   int max_steps);
        int n;
        n = 0;
        while (exp_state == st && n < max_steps) begin
            take_step(p, s, strike);
            n++;
        end
        if (exp_state == st) begin
            errors = errors + 1;
            $display("Test %s timed out after %0d steps, still in state %0d", test_name,
                     max_steps, st);
        end
    endtask

    task automatic start_test(string name);
        test_name     = name;
        errors_before = errors;
    endtask

    task automatic end_test();
        repeat (2) @(negedge frame_clk);   // Last check lands first
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("Test %s FAILED with %0d errors", test_name, errors - errors_before);
        end else begin
            $display("Test %s ok", test_name);
        end
    endtask

    initial begin
        tile_t p;
        tile_t s;
        tile_t sc;
        int    round;

        start_test("reset_values");
        apply_reset();
        end_test();

        start_test("scatter_walk");
        draw_tile(sc);
        write_cfg(cfg_scatter_tile, sc);
        draw_tile(p);
        draw_tile(s);
        step_until_left(beh_scatter, p, s, 1'b0, 20);
        end_test();

        start_test("contest_sheep");
        write_cfg(cfg_growth_limit, 8'h05);
        for (round = 0; round < 12; round++) begin
            draw_tile(p);
            draw_tile(s);
            step_until_left(beh_scatter, p, s, 1'b0, 40);
            if (round % 2 == 1) begin
                s = adjacent_tile(exp_head);                          // Sheep next door
                p = pick_target(beh_retreat, '0, exp_head, '0, '0);   // Player in far corner
            end else if (round == 10) begin
                s = adjacent_tile(exp_head);   // Equal distance so the sheep wins
                p = two_cols_away(exp_head);
            end
            step_until_left(beh_contest, p, s, 1'b0, 40);
        end
        end_test();

        start_test("player_caught");
        step_until_left(beh_scatter, p, s, 1'b0, 40);
        p = adjacent_tile(exp_head);
        s = pick_target(beh_retreat, '0, exp_head, '0, '0);
        step_until_left(beh_contest, p, s, 1'b0, 40);
        end_test();

        start_test("dragon_hurt");
        for (round = 0; round < 20 && exp_state != beh_dead; round++) begin
            step_until_left(beh_retreat, p, s, 1'b1, 40);   // Player held so the corner is fixed
            step_until_left(beh_scatter, p, s, 1'b1, 40);
            p = adjacent_tile(exp_head);
            s = pick_target(beh_retreat, '0, exp_head, '0, '0);
            step_until_left(beh_contest, p, s, 1'b1, 40);
        end
        if (exp_state != beh_dead) begin
            errors = errors + 1;
            $display("Test %s never reached the dead state", test_name);
        end
        for (round = 0; round < 4; round++) begin
            draw_tile(p);
            draw_tile(s);
            lfsr = lfsr_advance(lfsr);      // One step for the strike bit
            take_step(p, s, lfsr[0]);       // Dead so nothing should move
        end
        end_test();

        start_test("no_move_zero_limit");
        apply_reset();
        write_cfg(cfg_scatter_tile, `DRAGON_START_TILE + 8'd2);   // Two tiles right of start
        step_until_left(beh_scatter, p, s, 1'b0, 20);
        p = exp_head;                       // Caught in place with facing kept
        s = pick_target(beh_retreat, '0, exp_head, '0, '0);
        take_step(p, s, 1'b0);
        take_step(p, s, 1'b0);              // Scatter tile under the head
        write_cfg(cfg_growth_limit, 8'h00);
        s = adjacent_tile(exp_head);
        p = pick_target(beh_retreat, '0, exp_head, '0, '0);
        step_until_left(beh_contest, p, s, 1'b0, 40);
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
